// File: source/ddr_bridge_pkg.sv
package ddr_bridge_pkg;

    // command code as seen on the controller app port
    typedef logic [2:0] app_cmd_t;

    localparam app_cmd_t app_cmd_write = 3'b000;
    localparam app_cmd_t app_cmd_read  = 3'b001;   // other codes unused

    // bus widths of the ddr3 user interface
    localparam int default_data_width = 128;
    localparam int default_addr_width = 29;       // rank, bank, row, column
    localparam int default_id_width   = 4;

endpackage

// File: source/ram_cmd_accept.sv
`timescale 1ns/100ps

module ram_cmd_accept #(
    parameter int  cmd_depth  = 4,
    parameter type cmd_t      = logic,
    parameter int  data_width = ddr_bridge_pkg::default_data_width,
    parameter int  addr_width = ddr_bridge_pkg::default_addr_width,
    parameter int  id_width   = ddr_bridge_pkg::default_id_width,
    localparam int strb_width = data_width / 8,
    localparam int cnt_width  = $clog2(cmd_depth + 1)
) (
    input  logic                  clk_if,
    input  logic                  resetn,
    input  logic                  ram_cmd_wr_en,
    input  logic                  ram_cmd_rd_en,
    input  logic [id_width-1:0]   ram_cmd_id,
    input  logic [addr_width-1:0] ram_cmd_addr,
    input  logic [data_width-1:0] ram_cmd_wr_data,
    input  logic [strb_width-1:0] ram_cmd_wr_strb,
    input  logic                  ram_cmd_last,
    output logic                  ram_cmd_ready,
    input  logic [cnt_width-1:0]  cmd_count,
    output logic                  cmd_push,
    output cmd_t                  cmd_push_data
);

    logic accept;
    logic is_rd;
    logic room;

    assign accept = (ram_cmd_wr_en || ram_cmd_rd_en) && ram_cmd_ready;
    assign is_rd  = ram_cmd_rd_en && !ram_cmd_wr_en;   // write wins if both

    // two free slots, so one more push still fits after the registered ready
    assign room = (int'(cmd_count) + 2) <= cmd_depth;

    assign cmd_push = accept;

    always_comb begin
        cmd_push_data.rd   = is_rd;
        cmd_push_data.last = ram_cmd_last;
        cmd_push_data.id   = ram_cmd_id;
        cmd_push_data.data = is_rd ? '0 : ram_cmd_wr_data;
        cmd_push_data.strb = is_rd ? '0 : ram_cmd_wr_strb;
        cmd_push_data.addr = ram_cmd_addr;
    end

    always_ff @(posedge clk_if) begin
        if (!resetn) begin
            ram_cmd_ready <= 1'b0;
        end else begin
            ram_cmd_ready <= room && !accept;   // low for a cycle after every accept
        end
    end

endmodule

// File: source/sync_fifo.sv
`timescale 1ns/100ps

module sync_fifo #(
    parameter int  depth     = 4,
    parameter type payload_t = logic,
    localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1,
    localparam int cnt_width = $clog2(depth + 1)
) (
    input  logic                 clk_if,
    input  logic                 resetn,
    input  logic                 push,
    input  payload_t             push_data,
    input  logic                 pop,
    output payload_t             head,
    output logic                 empty,
    output logic                 full,
    output logic [cnt_width-1:0] count
);

    payload_t mem [depth];

    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic                 do_push;
    logic                 do_pop;

    assign empty = (count == '0);
    assign full  = (int'(count) == depth);

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign head = mem[rd_ptr];

    always_ff @(posedge clk_if) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk_if) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                // wrap by hand, depth need not be a power of two
                if (int'(wr_ptr) == depth - 1) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (do_pop) begin
                if (int'(rd_ptr) == depth - 1) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
        end
    end

endmodule

// File: source/app_cmd_issue.sv
`timescale 1ns/100ps

module app_cmd_issue #(
    parameter type cmd_t      = logic,
    parameter int  data_width = ddr_bridge_pkg::default_data_width,
    parameter int  addr_width = ddr_bridge_pkg::default_addr_width,
    parameter int  id_width   = ddr_bridge_pkg::default_id_width,
    localparam int strb_width = data_width / 8
) (
    input  logic                     clk_if,
    input  logic                     resetn,

    input  cmd_t                     cmd_head,
    input  logic                     cmd_empty,
    output logic                     cmd_pop,

    output ddr_bridge_pkg::app_cmd_t app_cmd,
    output logic                     app_cmd_en,
    output logic [addr_width-1:0]    app_addr,
    output logic [data_width-1:0]    app_wdf_data,
    output logic [strb_width-1:0]    app_wdf_mask,
    output logic                     app_wdf_wren,
    output logic                     app_wdf_end,
    input  logic                     app_cmd_ready,
    input  logic                     app_wdf_rdy,
    input  logic [data_width-1:0]    app_rd_data,
    input  logic                     app_rd_data_valid,

    output logic                     rd_push,
    output logic [data_width-1:0]    rd_push_data,
    input  logic [data_width-1:0]    rd_head,
    input  logic                     rd_empty,
    output logic                     rd_pop,

    input  logic                     ram_rd_resp_ready,
    output logic                     ram_rd_resp_valid,
    output logic [id_width-1:0]      ram_rd_resp_id,
    output logic [data_width-1:0]    ram_rd_resp_data,
    output logic                     ram_rd_resp_last
);

    typedef enum logic {
        st_idle,
        st_read
    } state_t;

    state_t state_q;

    logic                rd_done;   // beat of the open read has arrived
    logic                issue_wr;
    logic                issue_rd;
    logic [id_width-1:0] rd_id;
    logic                rd_last;

    // a write needs the data path free as well
    assign issue_wr = (state_q == st_idle) && !cmd_empty && !cmd_head.rd
                      && app_cmd_ready && app_wdf_rdy;
    assign issue_rd = (state_q == st_idle) && !cmd_empty && cmd_head.rd
                      && app_cmd_ready;

    assign cmd_pop = issue_wr || issue_rd;

    // one beat per read
    assign rd_push      = (state_q == st_read) && app_rd_data_valid && !rd_done;
    assign rd_push_data = app_rd_data;

    always_ff @(posedge clk_if) begin
        if (!resetn) begin
            state_q      <= st_idle;
            rd_done      <= 1'b0;
            app_cmd_en   <= 1'b0;
            app_wdf_wren <= 1'b0;
            app_wdf_end  <= 1'b0;
        end else begin
            app_cmd_en   <= issue_wr || issue_rd;
            app_wdf_wren <= issue_wr;
            app_wdf_end  <= issue_wr;   // single beat, so end with the data

            case (state_q)
                st_idle: begin
                    if (issue_rd) begin
                        state_q <= st_read;
                    end
                end
                st_read: begin
                    if (rd_push) begin
                        rd_done <= 1'b1;
                    end
                    // hold here until the response has left the buffer
                    if (rd_done && rd_empty) begin
                        state_q <= st_idle;
                        rd_done <= 1'b0;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk_if) begin
        if (issue_wr || issue_rd) begin
            app_cmd  <= issue_rd ? ddr_bridge_pkg::app_cmd_read
                                 : ddr_bridge_pkg::app_cmd_write;
            app_addr <= cmd_head.addr;
        end
        if (issue_wr) begin
            app_wdf_data <= cmd_head.data;
            app_wdf_mask <= ~cmd_head.strb;   // mask bit set = byte kept
        end
        if (issue_rd) begin
            rd_id   <= cmd_head.id;
            rd_last <= cmd_head.last;
        end
    end

    // response is offered only while the requester is ready
    assign ram_rd_resp_valid = !rd_empty && ram_rd_resp_ready;
    assign rd_pop            = ram_rd_resp_valid;
    assign ram_rd_resp_id    = rd_id;
    assign ram_rd_resp_data  = rd_head;
    assign ram_rd_resp_last  = rd_last;

endmodule

// File: source/ddr_app_bridge.sv
`timescale 1ns/100ps

module ddr_app_bridge #(
    parameter int  data_width = ddr_bridge_pkg::default_data_width,
    parameter int  addr_width = ddr_bridge_pkg::default_addr_width,
    parameter int  id_width   = ddr_bridge_pkg::default_id_width,
    parameter int  cmd_depth  = 4,
    parameter int  rd_depth   = 2,
    localparam int strb_width = data_width / 8
) (
    input  logic                     clk_if,
    input  logic                     resetn,

    input  logic                     ram_cmd_wr_en,
    input  logic                     ram_cmd_rd_en,
    input  logic [id_width-1:0]      ram_cmd_id,
    input  logic [addr_width-1:0]    ram_cmd_addr,
    input  logic [data_width-1:0]    ram_cmd_wr_data,
    input  logic [strb_width-1:0]    ram_cmd_wr_strb,
    input  logic                     ram_cmd_last,
    output logic                     ram_cmd_ready,

    output logic                     ram_rd_resp_valid,
    output logic [id_width-1:0]      ram_rd_resp_id,
    output logic [data_width-1:0]    ram_rd_resp_data,
    output logic                     ram_rd_resp_last,
    input  logic                     ram_rd_resp_ready,

    output ddr_bridge_pkg::app_cmd_t app_cmd,
    output logic                     app_cmd_en,
    output logic [addr_width-1:0]    app_addr,
    output logic [data_width-1:0]    app_wdf_data,
    output logic [strb_width-1:0]    app_wdf_mask,
    output logic                     app_wdf_wren,
    output logic                     app_wdf_end,
    input  logic                     app_cmd_ready,
    input  logic                     app_wdf_rdy,
    input  logic [data_width-1:0]    app_rd_data,
    input  logic                     app_rd_data_valid
);

    // one queued command, read flag on top
    typedef struct packed {
        logic                  rd;
        logic                  last;
        logic [id_width-1:0]   id;
        logic [data_width-1:0] data;
        logic [strb_width-1:0] strb;
        logic [addr_width-1:0] addr;
    } cmd_entry_t;

    typedef logic [data_width-1:0] rd_word_t;

    logic                           cmd_push;
    cmd_entry_t                     cmd_push_data;
    cmd_entry_t                     cmd_head;
    logic                           cmd_empty;
    logic                           cmd_pop;
    logic [$clog2(cmd_depth+1)-1:0] cmd_count;

    logic     rd_push;
    rd_word_t rd_push_data;
    rd_word_t rd_head;
    logic     rd_empty;
    logic     rd_pop;

    ram_cmd_accept #(
        .cmd_depth  (cmd_depth),
        .cmd_t      (cmd_entry_t),
        .data_width (data_width),
        .addr_width (addr_width),
        .id_width   (id_width)
    ) i_ram_cmd_accept (
        .clk_if          (clk_if),
        .resetn          (resetn),
        .ram_cmd_wr_en   (ram_cmd_wr_en),
        .ram_cmd_rd_en   (ram_cmd_rd_en),
        .ram_cmd_id      (ram_cmd_id),
        .ram_cmd_addr    (ram_cmd_addr),
        .ram_cmd_wr_data (ram_cmd_wr_data),
        .ram_cmd_wr_strb (ram_cmd_wr_strb),
        .ram_cmd_last    (ram_cmd_last),
        .ram_cmd_ready   (ram_cmd_ready),
        .cmd_count       (cmd_count),
        .cmd_push        (cmd_push),
        .cmd_push_data   (cmd_push_data)
    );

    sync_fifo #(
        .depth     (cmd_depth),
        .payload_t (cmd_entry_t)
    ) i_cmd_fifo (
        .clk_if    (clk_if),
        .resetn    (resetn),
        .push      (cmd_push),
        .push_data (cmd_push_data),
        .pop       (cmd_pop),
        .head      (cmd_head),
        .empty     (cmd_empty),
        .full      (),
        .count     (cmd_count)
    );

    // read beats waiting for the requester
    sync_fifo #(
        .depth     (rd_depth),
        .payload_t (rd_word_t)
    ) i_rd_fifo (
        .clk_if    (clk_if),
        .resetn    (resetn),
        .push      (rd_push),
        .push_data (rd_push_data),
        .pop       (rd_pop),
        .head      (rd_head),
        .empty     (rd_empty),
        .full      (),
        .count     ()
    );

    app_cmd_issue #(
        .cmd_t      (cmd_entry_t),
        .data_width (data_width),
        .addr_width (addr_width),
        .id_width   (id_width)
    ) i_app_cmd_issue (
        .clk_if            (clk_if),
        .resetn            (resetn),
        .cmd_head          (cmd_head),
        .cmd_empty         (cmd_empty),
        .cmd_pop           (cmd_pop),
        .app_cmd           (app_cmd),
        .app_cmd_en        (app_cmd_en),
        .app_addr          (app_addr),
        .app_wdf_data      (app_wdf_data),
        .app_wdf_mask      (app_wdf_mask),
        .app_wdf_wren      (app_wdf_wren),
        .app_wdf_end       (app_wdf_end),
        .app_cmd_ready     (app_cmd_ready),
        .app_wdf_rdy       (app_wdf_rdy),
        .app_rd_data       (app_rd_data),
        .app_rd_data_valid (app_rd_data_valid),
        .rd_push           (rd_push),
        .rd_push_data      (rd_push_data),
        .rd_head           (rd_head),
        .rd_empty          (rd_empty),
        .rd_pop            (rd_pop),
        .ram_rd_resp_ready (ram_rd_resp_ready),
        .ram_rd_resp_valid (ram_rd_resp_valid),
        .ram_rd_resp_id    (ram_rd_resp_id),
        .ram_rd_resp_data  (ram_rd_resp_data),
        .ram_rd_resp_last  (ram_rd_resp_last)
    );

endmodule

// File: tests/app_port_model.sv
`timescale 1ns/100ps

module app_port_model #(
    parameter int  data_width = ddr_bridge_pkg::default_data_width,
    parameter int  addr_width = ddr_bridge_pkg::default_addr_width,
    localparam int strb_width = data_width / 8
) (
    input  logic                     clk_if,
    input  logic [31:0]              rnd,        // fresh random word every cycle
    input  logic                     stall_en,
    input  ddr_bridge_pkg::app_cmd_t app_cmd,
    input  logic                     app_cmd_en,
    input  logic [addr_width-1:0]    app_addr,
    input  logic [data_width-1:0]    app_wdf_data,
    input  logic [strb_width-1:0]    app_wdf_mask,
    input  logic                     app_wdf_wren,
    input  logic                     app_wdf_end,
    output logic                     app_cmd_ready,
    output logic                     app_wdf_rdy,
    output logic [data_width-1:0]    app_rd_data,
    output logic                     app_rd_data_valid
);

    logic [data_width-1:0]    mem [logic [addr_width-1:0]];
    logic [data_width-1:0]    rd_q [$];
    int                       lat_q [$];    // cycles left for each pending read
    ddr_bridge_pkg::app_cmd_t cmd_log [$];  // command codes in issue order
    logic [1:0]               wdf_log [$];  // wren and end seen with each command

    // about one cycle in four stalled
    assign app_cmd_ready = !stall_en || (rnd[1:0] != 2'b00);
    assign app_wdf_rdy   = !stall_en || (rnd[3:2] != 2'b00);

    initial begin : app_sample
        logic [data_width-1:0] word;
        forever begin
            @(negedge clk_if);
            if (app_cmd_en) begin
                cmd_log.push_back(app_cmd);
                wdf_log.push_back({app_wdf_wren, app_wdf_end});
                // unwritten words read back as their own address
                word = mem.exists(app_addr) ? mem[app_addr] : data_width'(app_addr);
                if (app_cmd == ddr_bridge_pkg::app_cmd_write) begin
                    for (int b = 0; b < strb_width; b++) begin
                        if (!app_wdf_mask[b]) begin
                            word[8*b +: 8] = app_wdf_data[8*b +: 8];
                        end
                    end
                    mem[app_addr] = word;
                end else begin
                    rd_q.push_back(word);
                    lat_q.push_back(int'(rnd[10:8]) + 1);   // 1 to 8 cycles
                end
            end
        end
    end

    initial begin : rd_return
        app_rd_data_valid = 1'b0;
        app_rd_data       = '0;
        forever begin
            @(posedge clk_if);
            #1;
            app_rd_data_valid = 1'b0;
            if (lat_q.size() > 0) begin
                if (lat_q[0] > 1) begin
                    lat_q[0] = lat_q[0] - 1;
                end else begin
                    void'(lat_q.pop_front());
                    app_rd_data       = rd_q.pop_front();
                    app_rd_data_valid = 1'b1;
                end
            end
        end
    end

endmodule

// File: tests/tb_ddr_app_bridge.sv
`timescale 1ns/100ps

module tb_ddr_app_bridge;

    localparam int data_width = ddr_bridge_pkg::default_data_width;
    localparam int addr_width = ddr_bridge_pkg::default_addr_width;
    localparam int id_width   = ddr_bridge_pkg::default_id_width;
    localparam int strb_width = data_width / 8;
    localparam int max_lines  = 64;
    localparam int wait_limit = 400;   // cycles per wait loop

    logic                     clk_if;
    logic                     resetn;
    logic                     ram_cmd_wr_en;
    logic                     ram_cmd_rd_en;
    logic [id_width-1:0]      ram_cmd_id;
    logic [addr_width-1:0]    ram_cmd_addr;
    logic [data_width-1:0]    ram_cmd_wr_data;
    logic [strb_width-1:0]    ram_cmd_wr_strb;
    logic                     ram_cmd_last;
    logic                     ram_cmd_ready;
    logic                     ram_rd_resp_valid;
    logic [id_width-1:0]      ram_rd_resp_id;
    logic [data_width-1:0]    ram_rd_resp_data;
    logic                     ram_rd_resp_last;
    logic                     ram_rd_resp_ready;
    ddr_bridge_pkg::app_cmd_t app_cmd;
    logic                     app_cmd_en;
    logic [addr_width-1:0]    app_addr;
    logic [data_width-1:0]    app_wdf_data;
    logic [strb_width-1:0]    app_wdf_mask;
    logic                     app_wdf_wren;
    logic                     app_wdf_end;
    logic                     app_cmd_ready;
    logic                     app_wdf_rdy;
    logic [data_width-1:0]    app_rd_data;
    logic                     app_rd_data_valid;

    logic [31:0] rnd;
    logic        stall_en;
    int          resp_mode;   // 0 random, 1 held low, 2 held high

    // eight words per line: test, op, id, addr, data, strb, last, expected
    logic [127:0] case_words [max_lines*8];

    logic [id_width-1:0]   exp_id [$];
    logic [data_width-1:0] exp_data [$];
    logic                  exp_last [$];
    int                    check_count;
    int                    error_count;
    bit                    timed_out;

    ddr_app_bridge #(
        .data_width (data_width),
        .addr_width (addr_width),
        .id_width   (id_width),
        .cmd_depth  (4),
        .rd_depth   (2)
    ) i_dut (.*);

    app_port_model #(
        .data_width (data_width),
        .addr_width (addr_width)
    ) i_model (.*);

    assign ram_rd_resp_ready = (resp_mode == 0) ? (rnd[5:4] != 2'b00) : (resp_mode == 2);

    initial begin
        clk_if = 1'b0;
        forever begin
            #50 clk_if = ~clk_if;
        end
    end

    initial begin : random_gen
        void'($urandom(32'hd14e88f8));
        rnd = '0;
        forever begin
            @(posedge clk_if);
            #1;
            rnd = $urandom;
        end
    end

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("Fail %s: got %0h, expected %0h", name, got, expected);
        end
    endtask

    // called just after a rising edge, returns just after the accepting edge
    task automatic drive_cmd(input int i);
        int waited;
        bit taken;
        ram_cmd_rd_en   = (case_words[i*8+1] != 0);
        ram_cmd_wr_en   = (case_words[i*8+1] == 0);
        ram_cmd_id      = case_words[i*8+2][id_width-1:0];
        ram_cmd_addr    = case_words[i*8+3][addr_width-1:0];
        ram_cmd_wr_data = case_words[i*8+4][data_width-1:0];
        ram_cmd_wr_strb = case_words[i*8+5][strb_width-1:0];
        ram_cmd_last    = case_words[i*8+6][0];
        waited = 0;
        taken  = 1'b0;
        while (!taken && waited < wait_limit) begin
            @(negedge clk_if);
            taken = ram_cmd_ready;   // registered, stable until the edge
            @(posedge clk_if);
            #1;
            waited++;
        end
        if (!taken) begin
            $display("command on line %0d was never accepted by the bridge", i);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_drained(input int t, input int n_cmds);
        int waited;
        waited = 0;
        while ((exp_data.size() != 0 || i_model.cmd_log.size() < n_cmds)
               && waited < wait_limit) begin
            @(posedge clk_if);
            waited++;
        end
        if (exp_data.size() != 0 || i_model.cmd_log.size() < n_cmds) begin
            $display("test %0d timed out waiting for commands and read responses", t);
            timed_out = 1'b1;
        end
    endtask

    task automatic run_test(input int t, input int first, input int last_line);
        int log_base;
        int err_base;
        int chk_base;
        int n;
        log_base = i_model.cmd_log.size();
        err_base = error_count;
        chk_base = check_count;
        n        = last_line - first;
        @(posedge clk_if);
        #1;
        stall_en  = (t >= 4);
        resp_mode = (t == 2) ? 2 : ((t == 5) ? 1 : 0);
        for (int i = first; i < last_line && !timed_out; i++) begin
            if (case_words[i*8+1] != 0) begin
                exp_id.push_back(case_words[i*8+2][id_width-1:0]);
                exp_data.push_back(case_words[i*8+7][data_width-1:0]);
                exp_last.push_back(case_words[i*8+6][0]);
            end
            drive_cmd(i);
        end
        ram_cmd_wr_en = 1'b0;
        ram_cmd_rd_en = 1'b0;
        if (t == 5 && !timed_out) begin
            // first read stuck in the read buffer, the rest wait behind it
            repeat (20) @(posedge clk_if);
            #1;
            check_value("commands issued during hold", i_model.cmd_log.size(), log_base + 1);
            resp_mode = 2;
        end
        if (!timed_out) begin
            wait_drained(t, log_base + n);
        end
        for (int i = 0; i < n && !timed_out; i++) begin
            check_value("app_cmd", i_model.cmd_log[log_base + i],
                        (case_words[(first + i)*8+1] != 0) ? ddr_bridge_pkg::app_cmd_read
                                                           : ddr_bridge_pkg::app_cmd_write);
            // write data strobes go with write commands only
            check_value("app_wdf_wren/app_wdf_end", i_model.wdf_log[log_base + i],
                        (case_words[(first + i)*8+1] != 0) ? 2'b00 : 2'b11);
        end
        $display("test %0d: %0d commands, %0d checks, %0d errors", t, n,
                 check_count - chk_base, error_count - err_base);
    endtask

    initial begin : resp_monitor
        forever begin
            @(negedge clk_if);
            if (resp_mode == 1) begin
                check_value("ram_rd_resp_valid", ram_rd_resp_valid, 1'b0);
            end
            if (ram_rd_resp_valid === 1'b1) begin
                if (exp_data.size() == 0) begin
                    error_count++;
                    $display("read response id %0h came with no read outstanding",
                             ram_rd_resp_id);
                end else begin
                    check_value("ram_rd_resp_id", ram_rd_resp_id, exp_id.pop_front());
                    check_value("ram_rd_resp_data", ram_rd_resp_data, exp_data.pop_front());
                    check_value("ram_rd_resp_last", ram_rd_resp_last, exp_last.pop_front());
                end
            end
        end
    end

    initial begin : main_flow
        int n_lines;
        int line;
        int first;
        resetn          = 1'b0;
        ram_cmd_wr_en   = 1'b0;
        ram_cmd_rd_en   = 1'b0;
        ram_cmd_id      = '0;
        ram_cmd_addr    = '0;
        ram_cmd_wr_data = '0;
        ram_cmd_wr_strb = '0;
        ram_cmd_last    = 1'b0;
        stall_en        = 1'b0;
        resp_mode       = 2;
        check_count     = 0;
        error_count     = 0;
        timed_out       = 1'b0;
        $readmemh("tests/bridge_cases.txt", case_words);
        n_lines = 0;
        while (n_lines < max_lines && !$isunknown(case_words[n_lines*8])) begin
            n_lines++;
        end
        repeat (5) @(posedge clk_if);
        #1;
        resetn = 1'b1;
        @(negedge clk_if);   // no edge has seen the release yet
        check_value("ram_cmd_ready", ram_cmd_ready, 1'b0);
        check_value("app_cmd_en", app_cmd_en, 1'b0);
        check_value("app_wdf_wren", app_wdf_wren, 1'b0);
        check_value("app_wdf_end", app_wdf_end, 1'b0);
        check_value("ram_rd_resp_valid", ram_rd_resp_valid, 1'b0);
        $display("test 1: reset values, %0d checks, %0d errors", check_count, error_count);
        line = 0;
        while (line < n_lines && !timed_out) begin
            first = line;
            while (line < n_lines && case_words[line*8] == case_words[first*8]) begin
                line++;
            end
            run_test(int'(case_words[first*8]), first, line);
        end
        $display("summary: %0d checks, %0d errors%s", check_count, error_count,
                 timed_out ? ", stopped on a timeout" : "");
        if (error_count == 0 && !timed_out) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: tests/bridge_cases.txt
// test op id addr data strb last expected (all hex, op 0 write, op 1 read)
// expected is the data a read must return, zero on writes
2 0 1 0010 00112233445566778899aabbccddeeff ffff 1 0
2 1 2 0010 0 0 1 00112233445566778899aabbccddeeff
2 0 3 0010 ffeeddccbbaa99887766554433221100 00ff 1 0
2 1 4 0010 0 0 0 00112233445566777766554433221100
2 0 5 0020 0123456789abcdef0123456789abcdef ffff 1 0
2 0 6 0020 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 5555 1 0
2 1 7 0020 0 0 1 01a545a589a5cda501a545a589a5cda5
2 0 8 0010 ffffffffffffffffffffffffffffffff 0000 1 0
2 1 9 0010 0 0 1 00112233445566777766554433221100
3 1 a 0010 0 0 0 00112233445566777766554433221100
3 0 b 0030 0f0e0d0c0b0a09080706050403020100 ffff 0 0
3 1 c 0030 0 0 1 0f0e0d0c0b0a09080706050403020100
3 1 d 0020 0 0 0 01a545a589a5cda501a545a589a5cda5
3 1 e 0010 0 0 1 00112233445566777766554433221100
4 0 1 0100 11111111111111111111111111111111 ffff 1 0
4 0 2 0101 22222222222222222222222222222222 ffff 1 0
4 0 3 0100 33333333333333333333333333333333 f000 1 0
4 1 4 0100 0 0 1 33333333111111111111111111111111
4 1 5 0101 0 0 0 22222222222222222222222222222222
4 0 6 0102 deadbeefdeadbeefdeadbeefdeadbeef ffff 1 0
4 0 7 0101 44444444444444444444444444444444 000f 1 0
4 1 8 0102 0 0 1 deadbeefdeadbeefdeadbeefdeadbeef
4 1 9 0101 0 0 1 22222222222222222222222244444444
4 0 a 0100 55555555555555555555555555555555 0ff0 0 0
4 1 b 0100 0 0 0 33333333555555555555555511111111
5 1 1 0102 0 0 1 deadbeefdeadbeefdeadbeefdeadbeef
5 0 2 0103 66666666666666666666666666666666 ffff 1 0
5 1 3 0103 0 0 0 66666666666666666666666666666666

// File: ddr_app_bridge.f
source/ddr_bridge_pkg.sv
source/ram_cmd_accept.sv
source/sync_fifo.sv
source/app_cmd_issue.sv
source/ddr_app_bridge.sv
tests/app_port_model.sv
tests/tb_ddr_app_bridge.sv

// File: Bender.yml
package:
  name: ddr_app_bridge

sources:
  - source/ddr_bridge_pkg.sv
  - source/ram_cmd_accept.sv
  - source/sync_fifo.sv
  - source/app_cmd_issue.sv
  - source/ddr_app_bridge.sv
  - target: test
    files:
      - tests/app_port_model.sv
      - tests/tb_ddr_app_bridge.sv
